// File: fpMul.f
src/fpMulPkg.sv
src/baseMult.sv
src/recursiveKoa.sv
src/fpOperandUnpack.sv
src/fpNormalizer.sv
src/fpMulTop.sv
tb/tbClock.sv
tb/fpMulTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the multiplier testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fpMulTb \
    -f fpMul.f \
    -o fpMulSim

# The simulator exits non-zero on a failed check; the log decides the verdict
if ! ./obj_dir/fpMulSim > "$LOG" 2>&1; then
    echo "Simulator returned an error status"
fi
cat "$LOG"

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// File: src/baseMult.sv
// Schoolbook multiplier, the leaf of the Karatsuba recursion for narrow operands
`default_nettype none

module baseMult #(
    parameter int SW = 8
) (
    input  wire logic [SW-1:0]   dataA_i,
    input  wire logic [SW-1:0]   dataB_i,
    output logic      [2*SW-1:0] product_o
);

    // Running sum of partial products
    logic [2*SW-1:0] partialSum;

    always_comb begin
        partialSum = '0;
        // One shifted copy of A per set bit of B
        for (int i = 0; i < SW; i++) begin
            if (dataB_i[i]) begin
                partialSum = partialSum + ({{SW{1'b0}}, dataA_i} << i);
            end
        end
    end

    assign product_o = partialSum;

endmodule

`default_nettype wire

// File: src/fpMulPkg.sv
// Shared formats, width types and stage payloads for the single-precision multiplier
`default_nettype none

package fpMulPkg;

    // ====================
    // IEEE single format
    // ====================
    localparam int ExpWidth  = 8;
    localparam int FracWidth = 23;
    // Fraction plus hidden one
    localparam int SigWidth  = FracWidth + 1;
    localparam int ExpBias   = 127;

    // One packed single: sign, exponent, fraction
    typedef logic [ExpWidth+FracWidth:0] floatT;
    typedef logic [SigWidth-1:0] sigT;
    typedef logic [2*SigWidth-1:0] prodT;
    // Two guard bits, so eA + eB - bias stays in range
    typedef logic signed [ExpWidth+1:0] expSumT;

    // ====================
    // Stage payloads
    // ====================
    // Stage 1 out, operands split and exponents summed
    typedef struct packed {
        logic   sign;
        logic   isZero;
        sigT    sigA;
        sigT    sigB;
        expSumT expSum;
    } unpackedT;

    // Stage 2 out, raw significand product plus carried fields
    typedef struct packed {
        logic   sign;
        logic   isZero;
        expSumT expSum;
        prodT   prod;
    } productT;

endpackage

`default_nettype wire

// File: src/fpMulTop.sv
// Top level of the three-stage single-precision multiplier, one operation accepted per cycle
`default_nettype none

module fpMulTop #(
    // Recursion stops at this operand width
    parameter int BaseWidth = 8
) (
    input  wire logic            clk,
    input  wire logic            rst_i,
    input  wire logic            valid_i,
    input  wire fpMulPkg::floatT opA_i,
    input  wire fpMulPkg::floatT opB_i,
    output logic                 valid_o,
    output fpMulPkg::floatT      result_o
);

    // ====================
    // Stage signals
    // ====================
    // Stage 1 output
    fpMulPkg::unpackedT unpackedStage;
    logic               unpackedValid;

    // KOA output, combinational off stage 1
    fpMulPkg::prodT     sigProduct;

    // Stage 2 output
    fpMulPkg::productT  productStage;
    logic               productValid;

    // ====================
    // Stage 1: unpack
    // ====================
    fpOperandUnpack fpOperandUnpack_i (
        .clk    (clk),
        .rst_i  (rst_i),
        .valid_i(valid_i),
        .opA_i  (opA_i),
        .opB_i  (opB_i),
        .stage_o(unpackedStage),
        .valid_o(unpackedValid)
    );

    // ====================
    // Stage 2: multiply
    // ====================
    // 24x24 splits evenly to 12, whose middle of 13 splits oddly
    recursiveKoa #(
        .SW       (fpMulPkg::SigWidth),
        .BaseWidth(BaseWidth)
    ) recursiveKoa_i (
        .dataA_i  (unpackedStage.sigA),
        .dataB_i  (unpackedStage.sigB),
        .product_o(sigProduct)
    );

    // Valid bit of stage 2
    always_ff @(posedge clk) begin
        if (rst_i) begin
            productValid <= 1'b0;
        end else begin
            productValid <= unpackedValid;
        end
    end

    // Product plus fields carried from stage 1
    always_ff @(posedge clk) begin
        productStage.sign   <= unpackedStage.sign;
        productStage.isZero <= unpackedStage.isZero;
        productStage.expSum <= unpackedStage.expSum;
        productStage.prod   <= sigProduct;
    end

    // ====================
    // Stage 3: normalize
    // ====================
    fpNormalizer fpNormalizer_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (productValid),
        .stage_i (productStage),
        .valid_o (valid_o),
        .result_o(result_o)
    );

    // Fixed latency through all three stages
    assert property (@(posedge clk) disable iff (rst_i) valid_i |-> ##3 valid_o)
        else $error("valid_o missing three cycles after valid_i");

    // No result appears without a matching input
    assert property (@(posedge clk) disable iff (rst_i)
                     valid_o |-> $past(valid_i, 3))
        else $error("valid_o without a valid_i three cycles earlier");

endmodule

`default_nettype wire

// File: src/fpNormalizer.sv
// Stage 3 of the multiplier: normalizes the product, range-checks the exponent, packs the result
`default_nettype none

module fpNormalizer (
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic              valid_i,
    input  wire fpMulPkg::productT stage_i,
    output logic                   valid_o,
    output fpMulPkg::floatT        result_o
);

    // Product MSB, set when sig product is in [2, 4)
    localparam int TopBit = 2 * fpMulPkg::SigWidth - 1;
    // Largest biased exponent, reserved for infinity
    localparam fpMulPkg::expSumT ExpMax = fpMulPkg::expSumT'((1 << fpMulPkg::ExpWidth) - 1);

    logic [fpMulPkg::FracWidth-1:0] fracNorm;
    fpMulPkg::expSumT               expAdj;
    fpMulPkg::floatT                nextResult;

    // ====================
    // Normalize
    // ====================
    always_comb begin
        if (stage_i.prod[TopBit]) begin
            // One bit to the right, drop bit 47 as hidden one
            fracNorm = stage_i.prod[TopBit-1 -: fpMulPkg::FracWidth];
            expAdj   = stage_i.expSum + fpMulPkg::expSumT'(1);
        end else begin
            // Already in [1, 2), bit 46 is the hidden one
            fracNorm = stage_i.prod[TopBit-2 -: fpMulPkg::FracWidth];
            expAdj   = stage_i.expSum;
        end
    end

    // ====================
    // Range and pack
    // ====================
    always_comb begin
        if (stage_i.isZero || (expAdj < fpMulPkg::expSumT'(1))) begin
            // Flushed input or underflow, signed zero
            nextResult = {stage_i.sign, {(fpMulPkg::ExpWidth + fpMulPkg::FracWidth){1'b0}}};
        end else if (expAdj >= ExpMax) begin
            // Overflow, signed infinity
            nextResult = {stage_i.sign, {fpMulPkg::ExpWidth{1'b1}},
                          {fpMulPkg::FracWidth{1'b0}}};
        end else begin
            // Truncated, fraction bits below are simply dropped
            nextResult = {stage_i.sign, expAdj[fpMulPkg::ExpWidth-1:0], fracNorm};
        end
    end

    // Output register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        result_o <= nextResult;
    end

    // Two normalized significands multiply into [1, 4)
    // so the KOA result must have one of its top two bits set
    assert property (@(posedge clk) disable iff (rst_i)
                     (valid_i && !stage_i.isZero)
                     |-> (stage_i.prod[TopBit] || stage_i.prod[TopBit-1]))
        else $error("unnormalizable significand product %h", stage_i.prod);

endmodule

`default_nettype wire

// File: src/fpOperandUnpack.sv
// Stage 1 of the multiplier: splits both operands and registers sign, zero flag, sigs, exp sum
`default_nettype none

module fpOperandUnpack (
    input  wire logic            clk,
    input  wire logic            rst_i,
    input  wire logic            valid_i,
    input  wire fpMulPkg::floatT opA_i,
    input  wire fpMulPkg::floatT opB_i,
    output fpMulPkg::unpackedT   stage_o,
    output logic                 valid_o
);

    // Sign sits above exponent and fraction
    localparam int SignBit = fpMulPkg::ExpWidth + fpMulPkg::FracWidth;

    logic [fpMulPkg::ExpWidth-1:0] expA;
    logic [fpMulPkg::ExpWidth-1:0] expB;
    fpMulPkg::unpackedT            nextStage;

    // Biased exponent fields
    assign expA = opA_i[fpMulPkg::FracWidth +: fpMulPkg::ExpWidth];
    assign expB = opB_i[fpMulPkg::FracWidth +: fpMulPkg::ExpWidth];

    always_comb begin
        nextStage.sign   = opA_i[SignBit] ^ opB_i[SignBit];
        // Exponent zero means zero or denormal, both flushed
        nextStage.isZero = (expA == '0) || (expB == '0);
        // Hidden one in front of the fraction
        nextStage.sigA   = {1'b1, opA_i[fpMulPkg::FracWidth-1:0]};
        nextStage.sigB   = {1'b1, opB_i[fpMulPkg::FracWidth-1:0]};
        // Zero-extended then rebiased once
        nextStage.expSum = fpMulPkg::expSumT'(expA) + fpMulPkg::expSumT'(expB)
                         - fpMulPkg::expSumT'(fpMulPkg::ExpBias);
    end

    // ====================
    // Stage 1 register
    // ====================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Payload loads every cycle
    always_ff @(posedge clk) begin
        stage_o <= nextStage;
    end

    // Pipeline comes out of reset empty
    assert property (@(posedge clk) rst_i |=> !valid_o)
        else $error("stage 1 valid high right after reset");

endmodule

`default_nettype wire

// File: src/recursiveKoa.sv
// Recursive Karatsuba-Ofman multiplier, combinational, bottoming out in baseMult
`default_nettype none

module recursiveKoa #(
    parameter int SW        = 24,
    parameter int BaseWidth = 8
) (
    input  wire logic [SW-1:0]   dataA_i,
    input  wire logic [SW-1:0]   dataB_i,
    output logic      [2*SW-1:0] product_o
);

    generate
        if (SW <= BaseWidth) begin : genLeaf

            // Narrow enough, plain shift-and-add
            baseMult #(
                .SW(SW)
            ) baseMult_i (
                .dataA_i  (dataA_i),
                .dataB_i  (dataB_i),
                .product_o(product_o)
            );

        end else begin : genSplit

            // ====================
            // Split widths
            // ====================
            // Left half always SW/2
            localparam int LW = SW / 2;
            // Even split: SW/2, odd split: SW/2+1 so the halves cover SW
            localparam int RW = (SW % 2 == 0) ? SW / 2 : SW / 2 + 1;
            // Half sums carry one extra bit
            // Even: SW/2+1, odd: SW/2+2
            localparam int MW = RW + 1;

            // Half sums feeding the middle product
            logic [MW-1:0]   sumA;
            logic [MW-1:0]   sumB;

            // Sub-products
            logic [2*LW-1:0] qLeft;
            logic [2*RW-1:0] qRight;
            logic [2*MW-1:0] qMiddle;

            // Everything widened to the full result
            logic [2*SW-1:0] leftFull;
            logic [2*SW-1:0] rightFull;
            logic [2*SW-1:0] middleFull;
            logic [2*SW-1:0] crossTerm;

            // High part plus low part, per operand
            assign sumA = {{(MW-LW){1'b0}}, dataA_i[SW-1:RW]} + {1'b0, dataA_i[RW-1:0]};
            assign sumB = {{(MW-LW){1'b0}}, dataB_i[SW-1:RW]} + {1'b0, dataB_i[RW-1:0]};

            recursiveKoa #(
                .SW       (LW),
                .BaseWidth(BaseWidth)
            ) leftKoa_i (
                .dataA_i  (dataA_i[SW-1:RW]),
                .dataB_i  (dataB_i[SW-1:RW]),
                .product_o(qLeft)
            );

            recursiveKoa #(
                .SW       (RW),
                .BaseWidth(BaseWidth)
            ) rightKoa_i (
                .dataA_i  (dataA_i[RW-1:0]),
                .dataB_i  (dataB_i[RW-1:0]),
                .product_o(qRight)
            );

            recursiveKoa #(
                .SW       (MW),
                .BaseWidth(BaseWidth)
            ) middleKoa_i (
                .dataA_i  (sumA),
                .dataB_i  (sumB),
                .product_o(qMiddle)
            );

            // ====================
            // Recombination
            // ====================
            assign leftFull   = {{(2*SW-2*LW){1'b0}}, qLeft};
            assign rightFull  = {{(2*SW-2*RW){1'b0}}, qRight};
            assign middleFull = {{(2*SW-2*MW){1'b0}}, qMiddle};

            // aH*bL + aL*bH, never negative
            assign crossTerm = middleFull - leftFull - rightFull;

            // Left at 2*RW, cross terms at RW, right in place
            assign product_o = (leftFull << (2 * RW)) + (crossTerm << RW) + rightFull;

        end
    endgenerate

endmodule

`default_nettype wire

// File: tb/fpMulTb.sv
// Directed and random testbench for the pipelined multiplier, run as the simulation top
`default_nettype none

module fpMulTb;

    // ====================
    // Run limits
    // ====================
    localparam int DriveDelay     = 10;
    localparam int ResetCycles    = 5;
    localparam int DrainLimit     = 8;
    localparam int StreamOps      = 200;
    localparam int MaxGap         = 3;
    // Per-test cycle budgets
    localparam int LatencyBudget  = 3 + 4 + DrainLimit;
    localparam int DirectedBudget = 3 * (8 + DrainLimit);
    localparam int StreamBudget   = StreamOps * (MaxGap + 1) + DrainLimit;
    localparam int PlannedCycles  = ResetCycles + LatencyBudget + DirectedBudget + StreamBudget;
    localparam int TimeoutCycles  = 2 * PlannedCycles + 50;

    logic        clk;
    logic        rst;
    logic        validIn;
    logic [31:0] opA;
    logic [31:0] opB;
    logic        validOut;
    logic [31:0] result;

    // Expected results, oldest first
    logic [31:0] expQ[$];
    int          cycleCount = 0;

    tbClock #(
        .Period(100)
    ) tbClock_i (
        .clk_o(clk)
    );

    fpMulTop fpMulTop_i (
        .clk     (clk),
        .rst_i   (rst),
        .valid_i (validIn),
        .opA_i   (opA),
        .opB_i   (opB),
        .valid_o (validOut),
        .result_o(result)
    );

    // ====================
    // Reporting
    // ====================
    task automatic failRun(input string msg);
        $display("ERROR: %s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s actual 0x%h expected 0x%h", name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped at first error");
        end
    endtask

    // ====================
    // Reference model
    // ====================
    // Flush, exact 48-bit product, one-bit normalize, truncate, clamp
    function automatic logic [31:0] modelMul(input logic [31:0] a, input logic [31:0] b);
        logic        sign;
        int          expA;
        int          expB;
        int          expR;
        logic [47:0] sigA;
        logic [47:0] sigB;
        logic [47:0] prod;
        logic [22:0] frac;
        sign = a[31] ^ b[31];
        expA = int'(a[30:23]);
        expB = int'(b[30:23]);
        if (expA == 0 || expB == 0) begin
            return {sign, 31'd0};
        end
        sigA = {24'd0, 1'b1, a[22:0]};
        sigB = {24'd0, 1'b1, b[22:0]};
        prod = sigA * sigB;
        expR = expA + expB - 127;
        if (prod[47]) begin
            frac = prod[46:24];
            expR = expR + 1;
        end else begin
            frac = prod[45:23];
        end
        if (expR < 1) begin
            return {sign, 31'd0};
        end
        if (expR >= 255) begin
            return {sign, 8'hFF, 23'd0};
        end
        return {sign, 8'(expR), frac};
    endfunction

    // Finite operand, exponent 1 to 254
    function automatic logic [31:0] randomFloat();
        logic [7:0] e;
        e = 8'($urandom_range(254, 1));
        return {1'($urandom()), e, 23'($urandom())};
    endfunction

    // ====================
    // Driving helpers
    // ====================
    // Next edge, then a little later so inputs never race the clock
    task automatic stepCycle();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic issueOp(input logic [31:0] a, input logic [31:0] b);
        opA     = a;
        opB     = b;
        validIn = 1'b1;
        expQ.push_back(modelMul(a, b));
        stepCycle();
        validIn = 1'b0;
    endtask

    // Wait for all outstanding results
    task automatic drainPipe();
        for (int i = 0; i < DrainLimit && expQ.size() != 0; i++) begin
            stepCycle();
        end
        if (expQ.size() != 0) begin
            failRun($sformatf("valid_o never came for %0d issued operations", expQ.size()));
        end
    endtask

    // Result checker, samples midway through the cycle
    always @(negedge clk) begin : monitorResults
        logic [31:0] expVal;
        if (!rst && $isunknown(validOut)) begin
            failRun("valid_o is unknown after reset");
        end else if (!rst && validOut) begin
            if (expQ.size() == 0) begin
                failRun("valid_o went high with no operation outstanding");
            end else begin
                expVal = expQ.pop_front();
                checkValue("result_o", result, expVal);
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            failRun($sformatf("timeout after %0d cycles", cycleCount));
        end
    end

    // ====================
    // Tests
    // ====================
    task automatic testResetLatency();
        for (int i = 0; i < ResetCycles; i++) begin
            stepCycle();
            checkValue("valid_o", 32'(validOut), 32'd0);
        end
        rst = 1'b0;
        repeat (3) begin
            stepCycle();
            checkValue("valid_o", 32'(validOut), 32'd0);
        end
        // 1.5 x 2.0, sampling edge loads stage 1
        // Stage 2 and output register follow on the next two edges
        issueOp(32'h3FC00000, 32'h40000000);
        for (int k = 1; k <= 3; k++) begin
            stepCycle();
            checkValue("valid_o", 32'(validOut), (k == 2) ? 32'd1 : 32'd0);
            if (k == 2) begin
                checkValue("result_o", result, 32'h40400000);
            end
        end
        drainPipe();
    endtask

    task automatic testSigProduct();
        // Bit 47 set
        issueOp(32'h3FC00000, 32'h3FC00000);
        issueOp(32'h3FFFFFFF, 32'h3FFFFFFF);
        // Bit 47 clear
        issueOp(32'h3F800000, 32'h3F800000);
        issueOp(32'h3FFFFFFF, 32'h3F800000);
        issueOp(32'h3F800001, 32'h3F800001);
        // Mixed bit patterns through all KOA halves
        issueOp(32'h40490FDB, 32'h402DF854);
        issueOp(32'h3FAAAAAA, 32'h3FD55555);
        issueOp(32'h7F7FFFFF, 32'h3F000000);
        drainPipe();
    endtask

    task automatic testZeroSign();
        issueOp(32'h00000000, 32'h3F800000);
        issueOp(32'h80000000, 32'h3F800000);
        // Denormals flush to zero
        issueOp(32'h00400000, 32'hC0000000);
        issueOp(32'h3F800000, 32'h807FFFFF);
        issueOp(32'h80000000, 32'h80000000);
        // All four sign pairings
        issueOp(32'hBFC00000, 32'h40000000);
        issueOp(32'hBFC00000, 32'hC0000000);
        issueOp(32'h3FC00000, 32'hC0000000);
        drainPipe();
    endtask

    task automatic testRangeLimits();
        // Exponent 255 saturates, 254 just fits
        issueOp(32'h7F000000, 32'h40000000);
        issueOp(32'h7F000000, 32'h3F800000);
        issueOp(32'h7F400000, 32'h3FC00000);
        issueOp(32'hFF000000, 32'h40000000);
        // Exponent 0 flushes, 1 just fits
        issueOp(32'h00800000, 32'h3F000000);
        issueOp(32'h00800000, 32'h3F800000);
        // Normalization carry lifts exponent 0 back to 1
        issueOp(32'h00C00000, 32'h3F400000);
        issueOp(32'h80800000, 32'h3F000000);
        drainPipe();
    endtask

    task automatic testStream();
        logic [31:0] a;
        logic [31:0] b;
        int          gap;
        for (int n = 0; n < StreamOps; n++) begin
            a = randomFloat();
            b = randomFloat();
            issueOp(a, b);
            // Mostly back to back, sometimes a short bubble
            gap = ($urandom_range(3, 0) == 0) ? int'($urandom_range(MaxGap, 1)) : 0;
            repeat (gap) stepCycle();
        end
        drainPipe();
    endtask

    initial begin
        rst     = 1'b1;
        validIn = 1'b0;
        opA     = '0;
        opB     = '0;
        void'($urandom(32'ha37e));

        testResetLatency();
        testSigProduct();
        testZeroSign();
        testRangeLimits();
        testStream();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tbClock.sv
// Free-running testbench clock, instantiated by the multiplier testbench
`default_nettype none

module tbClock #(
    parameter int Period = 100
) (
    output logic clk_o
);

    // Starts low, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(Period / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire
